// ==== hdl/ldpc_enc_pkg.sv ====
//--------------------------------------------------------------------------
// QC LDPC encoder shared definitions
// fixed code geometry, base matrix table, datapath types and FSM states
//--------------------------------------------------------------------------
package ldpc_enc_pkg;

  // code geometry
  localparam int cZ          = 8;
  localparam int cLOG2_Z     = 3;
  localparam int cKB         = 4;
  localparam int cMB         = 4;
  localparam int cNB         = cKB + cMB;
  localparam int cHS_NUM     = 12;
  // table entries per data column
  localparam int cHS_PER_COL = cHS_NUM / cKB;

  // pipeline latencies
  localparam int cRDAT_DELAY = 2;
  localparam int cROT_DELAY  = 2;
  // table reg + buffer read + rotator + accumulate
  localparam int cDRAIN_CYCLES = 1 + cRDAT_DELAY + cROT_DELAY + 1;

  typedef logic [cZ-1:0]              zdat_t;
  typedef logic [$clog2(cNB)-1:0]     col_t;
  typedef logic [$clog2(cMB)-1:0]     row_t;
  typedef logic [cLOG2_Z-1:0]         shift_t;
  typedef logic [$clog2(cHS_NUM)-1:0] cycle_idx_t;

  typedef struct packed {
    col_t   col;
    row_t   row;
    shift_t shift;
  } hs_entry_t;

  //------------------------------------------------------------------------
  // base matrix, grouped by column, three circulants each
  //------------------------------------------------------------------------
  localparam hs_entry_t cHS_TABLE [cHS_NUM] = '{
    '{col: 3'd0, row: 2'd0, shift: 3'd1},
    '{col: 3'd0, row: 2'd1, shift: 3'd4},
    '{col: 3'd0, row: 2'd3, shift: 3'd7},
    '{col: 3'd1, row: 2'd0, shift: 3'd2},
    '{col: 3'd1, row: 2'd2, shift: 3'd6},
    '{col: 3'd1, row: 2'd3, shift: 3'd1},
    '{col: 3'd2, row: 2'd1, shift: 3'd0},
    '{col: 3'd2, row: 2'd2, shift: 3'd3},
    '{col: 3'd2, row: 2'd0, shift: 3'd5},
    '{col: 3'd3, row: 2'd1, shift: 3'd2},
    '{col: 3'd3, row: 2'd3, shift: 3'd5},
    '{col: 3'd3, row: 2'd2, shift: 3'd0}
  };

  // frame controller states
  typedef enum logic [2:0] {
    st_idle,
    st_cycle,
    st_drain,
    st_parity,
    st_release
  } ctrl_state_t;

endpackage

// ==== hdl/ldpc_enc_entry_if.sv ====
//--------------------------------------------------------------------------
// Hs table entry bus
// one base matrix entry per cycle from the table to the rotator
//--------------------------------------------------------------------------
`timescale 1ns/10ps

interface ldpc_enc_entry_if;

  // no flow control, val may stay high back to back
  logic                    val;
  // first entry of a column, marks the data copy
  logic                    first;
  // last entry of the table walk
  logic                    last;
  ldpc_enc_pkg::hs_entry_t entry;

  modport src (output val, first, last, entry);
  modport dst (input  val, first, last, entry);

endinterface

// ==== hdl/ldpc_enc_hs_table.sv ====
//--------------------------------------------------------------------------
// Hs table
// registered base matrix lookup by cycle index, drives the buffer address
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module ldpc_enc_hs_table (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     icycle_read,
  input  ldpc_enc_pkg::cycle_idx_t icycle_idx,
  output ldpc_enc_pkg::col_t       oraddr,
  ldpc_enc_entry_if.src            entry
);

  ldpc_enc_pkg::hs_entry_t lookup;

  // rom read
  assign lookup = ldpc_enc_pkg::cHS_TABLE[icycle_idx];

  //------------------------------------------------------------------------
  // entry valid
  //------------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      entry.val <= 1'b0;
    end
    else begin
      entry.val <= icycle_read;
    end
  end

  // entry payload and read address, same cycle as val
  always_ff @(posedge iclk) begin
    if (icycle_read) begin
      entry.entry <= lookup;
      entry.first <= (icycle_idx % ldpc_enc_pkg::cHS_PER_COL) == 0;
      entry.last  <= icycle_idx == ldpc_enc_pkg::cycle_idx_t'(ldpc_enc_pkg::cHS_NUM - 1);
      // column doubles as input buffer word address
      oraddr      <= lookup.col;
    end
  end

endmodule

// ==== hdl/ldpc_enc_ctrl.sv ====
//--------------------------------------------------------------------------
// frame controller
// start on full/empty buffers, walk the table, drain, read parity rows,
// then release the input buffer and hand the output frame over
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module ldpc_enc_ctrl (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     irbuf_full,
  input  logic                     iwbuf_empty,
  output logic                     ostart,
  output logic                     ocycle_read,
  output ldpc_enc_pkg::cycle_idx_t ocycle_idx,
  output logic                     orempty,
  output logic                     op_read,
  output ldpc_enc_pkg::row_t       op_row,
  input  logic                     ilast_write,
  output logic                     owfull
);

  ldpc_enc_pkg::ctrl_state_t                      state;
  ldpc_enc_pkg::cycle_idx_t                       cycle_idx;
  logic [$clog2(ldpc_enc_pkg::cDRAIN_CYCLES)-1:0] drain_cnt;
  ldpc_enc_pkg::row_t                             prow;

  // start only with both buffers ready and the last owfull gone
  assign ostart      = (state == ldpc_enc_pkg::st_idle) & irbuf_full & iwbuf_empty & ~owfull;
  assign ocycle_read = (state == ldpc_enc_pkg::st_cycle);
  assign ocycle_idx  = cycle_idx;
  assign op_read     = (state == ldpc_enc_pkg::st_parity);
  assign op_row      = prow;

  //------------------------------------------------------------------------
  // FSM
  //------------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state     <= ldpc_enc_pkg::st_idle;
      cycle_idx <= '0;
      drain_cnt <= '0;
      prow      <= '0;
      orempty   <= 1'b0;
      owfull    <= 1'b0;
    end
    else begin
      // single cycle pulses
      orempty <= 1'b0;
      owfull  <= 1'b0;
      case (state)
        ldpc_enc_pkg::st_idle: begin
          cycle_idx <= '0;
          if (ostart) begin
            state <= ldpc_enc_pkg::st_cycle;
          end
        end
        // one table entry per clock
        ldpc_enc_pkg::st_cycle: begin
          cycle_idx <= cycle_idx + 1'b1;
          if (cycle_idx == ldpc_enc_pkg::cycle_idx_t'(ldpc_enc_pkg::cHS_NUM - 1)) begin
            state     <= ldpc_enc_pkg::st_drain;
            drain_cnt <= '0;
            // all reads issued, input buffer free
            orempty   <= 1'b1;
          end
        end
        // wait for the last accumulate to land
        ldpc_enc_pkg::st_drain: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == ($bits(drain_cnt))'(ldpc_enc_pkg::cDRAIN_CYCLES - 1)) begin
            state <= ldpc_enc_pkg::st_parity;
            prow  <= '0;
          end
        end
        // row reads back to back
        ldpc_enc_pkg::st_parity: begin
          prow <= prow + 1'b1;
          if (prow == ldpc_enc_pkg::row_t'(ldpc_enc_pkg::cMB - 1)) begin
            state <= ldpc_enc_pkg::st_release;
          end
        end
        ldpc_enc_pkg::st_release: begin
          if (ilast_write) begin
            owfull <= 1'b1;
            state  <= ldpc_enc_pkg::st_idle;
          end
        end
        default: begin
          state <= ldpc_enc_pkg::st_idle;
        end
      endcase
    end
  end

  // buffer release follows a full table walk
  a_start_walk : assert property (@(posedge iclk) disable iff (ireset)
    ostart |-> ##(ldpc_enc_pkg::cHS_NUM + 1) orempty);

endmodule

// ==== hdl/ldpc_enc_rotator.sv ====
//--------------------------------------------------------------------------
// circulant rotator
// aligns table entries with buffer read data, then rotates left in two
// pipeline stages for the parity accumulators
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module ldpc_enc_rotator (
  input  logic                iclk,
  input  logic                ireset,
  ldpc_enc_entry_if.dst       entry,
  input  ldpc_enc_pkg::zdat_t irdat,
  output logic                odat_val,
  output ldpc_enc_pkg::col_t  odat_col,
  output ldpc_enc_pkg::zdat_t odat,
  output logic                orot_val,
  output ldpc_enc_pkg::row_t  orot_row,
  output ldpc_enc_pkg::zdat_t orot
);

  localparam int cD = ldpc_enc_pkg::cRDAT_DELAY;

  logic [cD-1:0]         val_d;
  logic [cD-1:0]         first_d;
  ldpc_enc_pkg::col_t    col_d   [cD];
  ldpc_enc_pkg::row_t    row_d   [cD];
  ldpc_enc_pkg::shift_t  shift_d [cD];
  // first rotate stage
  logic                  s1_val;
  ldpc_enc_pkg::row_t    s1_row;
  logic [1:0]            s1_shift;
  ldpc_enc_pkg::zdat_t   s1_dat;

  function automatic ldpc_enc_pkg::zdat_t rotl(ldpc_enc_pkg::zdat_t d, int n);
    logic [2*ldpc_enc_pkg::cZ-1:0] dd;
    dd = {d, d} << n;
    return dd[2*ldpc_enc_pkg::cZ-1 -: ldpc_enc_pkg::cZ];
  endfunction

  //------------------------------------------------------------------------
  // read latency alignment
  //------------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_d    <= '0;
      s1_val   <= 1'b0;
      orot_val <= 1'b0;
    end
    else begin
      val_d    <= {val_d[cD-2:0], entry.val};
      s1_val   <= val_d[cD-1];
      orot_val <= s1_val;
    end
  end

  always_ff @(posedge iclk) begin
    first_d <= {first_d[cD-2:0], entry.first};
    for (int i = 0; i < cD; i++) begin
      col_d[i]   <= (i == 0) ? entry.entry.col   : col_d[i-1];
      row_d[i]   <= (i == 0) ? entry.entry.row   : row_d[i-1];
      shift_d[i] <= (i == 0) ? entry.entry.shift : shift_d[i-1];
    end
    // stage 1 by bit 0, stage 2 by bits 2..1
    s1_dat   <= shift_d[cD-1][0] ? rotl(irdat, 1) : irdat;
    s1_shift <= shift_d[cD-1][2:1];
    s1_row   <= row_d[cD-1];
    orot     <= rotl(s1_dat, 2 * int'(s1_shift));
    orot_row <= s1_row;
  end

  // unrotated word, one copy per column
  assign odat_val = val_d[cD-1] & first_d[cD-1];
  assign odat_col = col_d[cD-1];
  assign odat     = irdat;

  // table walk ends after the last entry
  a_walk_end : assert property (@(posedge iclk) disable iff (ireset)
    (entry.val && entry.last) |=> !entry.val);

endmodule

// ==== hdl/ldpc_enc_pacc.sv ====
//--------------------------------------------------------------------------
// parity accumulators
// one xor register per parity row, cleared per frame, single read port
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module ldpc_enc_pacc (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                istart,
  input  logic                ival,
  input  ldpc_enc_pkg::row_t  irow,
  input  ldpc_enc_pkg::zdat_t idat,
  input  logic                iread,
  input  ldpc_enc_pkg::row_t  iread_row,
  output logic                oval,
  output ldpc_enc_pkg::zdat_t odat
);

  ldpc_enc_pkg::zdat_t acc [ldpc_enc_pkg::cMB];

  //------------------------------------------------------------------------
  // accumulate
  //------------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      for (int r = 0; r < ldpc_enc_pkg::cMB; r++) begin
        acc[r] <= '0;
      end
    end
    else if (istart) begin
      for (int r = 0; r < ldpc_enc_pkg::cMB; r++) begin
        acc[r] <= '0;
      end
    end
    else if (ival) begin
      // rotated word into its row
      acc[irow] <= acc[irow] ^ idat;
    end
  end

  //------------------------------------------------------------------------
  // row read, 1 cycle
  //------------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end
    else begin
      oval <= iread;
    end
  end

  always_ff @(posedge iclk) begin
    odat <= acc[iread_row];
  end

  // pipeline is empty when a new frame clears the rows
  a_start_idle : assert property (@(posedge iclk) disable iff (ireset)
    istart |-> !ival);

endmodule

// ==== hdl/ldpc_enc_out_mux.sv ====
//--------------------------------------------------------------------------
// output writer
// data copies to words 0..3, dual diagonal parity chain to words 4..7
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module ldpc_enc_out_mux (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                istart,
  input  logic                idat_val,
  input  ldpc_enc_pkg::col_t  idat_col,
  input  ldpc_enc_pkg::zdat_t idat,
  input  logic                ipval,
  input  ldpc_enc_pkg::zdat_t ipacc,
  output logic                owrite,
  output ldpc_enc_pkg::col_t  owaddr,
  output ldpc_enc_pkg::zdat_t owdat,
  output logic                olast_write
);

  ldpc_enc_pkg::row_t  pcnt;
  ldpc_enc_pkg::zdat_t pline;
  ldpc_enc_pkg::zdat_t pline_nxt;

  // parity r = parity r-1 ^ acc r
  assign pline_nxt = pline ^ ipacc;

  //------------------------------------------------------------------------
  // write strobe and parity chain state
  //------------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      owrite      <= 1'b0;
      olast_write <= 1'b0;
      pcnt        <= '0;
      pline       <= '0;
    end
    else begin
      owrite      <= idat_val | ipval;
      olast_write <= ipval & (pcnt == ldpc_enc_pkg::row_t'(ldpc_enc_pkg::cMB - 1));
      if (istart) begin
        pcnt  <= '0;
        pline <= '0;
      end
      else if (ipval) begin
        pcnt  <= pcnt + 1'b1;
        pline <= pline_nxt;
      end
    end
  end

  // address and data
  always_ff @(posedge iclk) begin
    if (ipval) begin
      owaddr <= ldpc_enc_pkg::col_t'(ldpc_enc_pkg::cKB) + ldpc_enc_pkg::col_t'(pcnt);
      owdat  <= pline_nxt;
    end
    else begin
      owaddr <= idat_col;
      owdat  <= idat;
    end
  end

  // data copies finish long before the parity readout
  a_src_excl : assert property (@(posedge iclk) disable iff (ireset)
    !(idat_val && ipval));

endmodule

// ==== hdl/ldpc_enc_engine.sv ====
//--------------------------------------------------------------------------
// QC LDPC encoder engine
// fixed DVB type code, input buffer in, systematic frame out
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module ldpc_enc_engine (
  input  logic                iclk,
  input  logic                ireset,
  // input buffer
  input  logic                irbuf_full,
  input  ldpc_enc_pkg::zdat_t irdat,
  output ldpc_enc_pkg::col_t  oraddr,
  output logic                orempty,
  // output buffer
  input  logic                iwbuf_empty,
  output logic                owrite,
  output ldpc_enc_pkg::col_t  owaddr,
  output ldpc_enc_pkg::zdat_t owdat,
  output logic                owfull
);

  logic                     ctrl__ostart;
  logic                     ctrl__ocycle_read;
  ldpc_enc_pkg::cycle_idx_t ctrl__ocycle_idx;
  logic                     ctrl__op_read;
  ldpc_enc_pkg::row_t       ctrl__op_row;
  // rotator outputs
  logic                     rot__odat_val;
  ldpc_enc_pkg::col_t       rot__odat_col;
  ldpc_enc_pkg::zdat_t      rot__odat;
  logic                     rot__orot_val;
  ldpc_enc_pkg::row_t       rot__orot_row;
  ldpc_enc_pkg::zdat_t      rot__orot;
  // accumulator read
  logic                     pacc__oval;
  ldpc_enc_pkg::zdat_t      pacc__odat;
  logic                     mux__olast_write;

  ldpc_enc_entry_if entry_if ();

  //------------------------------------------------------------------------
  // control and table
  //------------------------------------------------------------------------
  ldpc_enc_ctrl u_ctrl (
    .iclk        ( iclk              ),
    .ireset      ( ireset            ),
    .irbuf_full  ( irbuf_full        ),
    .iwbuf_empty ( iwbuf_empty       ),
    .ostart      ( ctrl__ostart      ),
    .ocycle_read ( ctrl__ocycle_read ),
    .ocycle_idx  ( ctrl__ocycle_idx  ),
    .orempty     ( orempty           ),
    .op_read     ( ctrl__op_read     ),
    .op_row      ( ctrl__op_row      ),
    .ilast_write ( mux__olast_write  ),
    .owfull      ( owfull            )
  );

  ldpc_enc_hs_table u_hs_table (
    .iclk        ( iclk              ),
    .ireset      ( ireset            ),
    .icycle_read ( ctrl__ocycle_read ),
    .icycle_idx  ( ctrl__ocycle_idx  ),
    .oraddr      ( oraddr            ),
    .entry       ( entry_if          )
  );

  //------------------------------------------------------------------------
  // datapath
  //------------------------------------------------------------------------
  ldpc_enc_rotator u_rotator (
    .iclk     ( iclk          ),
    .ireset   ( ireset        ),
    .entry    ( entry_if      ),
    .irdat    ( irdat         ),
    .odat_val ( rot__odat_val ),
    .odat_col ( rot__odat_col ),
    .odat     ( rot__odat     ),
    .orot_val ( rot__orot_val ),
    .orot_row ( rot__orot_row ),
    .orot     ( rot__orot     )
  );

  ldpc_enc_pacc u_pacc (
    .iclk      ( iclk          ),
    .ireset    ( ireset        ),
    .istart    ( ctrl__ostart  ),
    .ival      ( rot__orot_val ),
    .irow      ( rot__orot_row ),
    .idat      ( rot__orot     ),
    .iread     ( ctrl__op_read ),
    .iread_row ( ctrl__op_row  ),
    .oval      ( pacc__oval    ),
    .odat      ( pacc__odat    )
  );

  ldpc_enc_out_mux u_out_mux (
    .iclk        ( iclk             ),
    .ireset      ( ireset           ),
    .istart      ( ctrl__ostart     ),
    .idat_val    ( rot__odat_val    ),
    .idat_col    ( rot__odat_col    ),
    .idat        ( rot__odat        ),
    .ipval       ( pacc__oval       ),
    .ipacc       ( pacc__odat       ),
    .owrite      ( owrite           ),
    .owaddr      ( owaddr           ),
    .owdat       ( owdat            ),
    .olast_write ( mux__olast_write )
  );

endmodule

// ==== dv/ldpc_enc_checker.sv ====
//--------------------------------------------------------------------------
// LDPC encoder checker
// reference encoder, frame compare and handshake checks with error count
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module ldpc_enc_checker (
  input  logic                iclk,
  input  logic                ireset,
  input  ldpc_enc_pkg::col_t  rd_addr,
  input  logic                rd_release,
  input  logic                wbuf_empty,
  input  logic                wr_en,
  input  ldpc_enc_pkg::col_t  wr_addr,
  input  ldpc_enc_pkg::zdat_t wr_dat,
  input  logic                wr_full,
  input  logic                load,
  input  logic [ldpc_enc_pkg::cKB*ldpc_enc_pkg::cZ-1:0] load_words,
  output int                  errors,
  output int                  frames
);

  localparam int cW = ldpc_enc_pkg::cZ;

  // input frames waiting for their output frame
  logic [ldpc_enc_pkg::cKB*cW-1:0] exp_q [$];
  ldpc_enc_pkg::zdat_t             got [ldpc_enc_pkg::cNB];
  logic [ldpc_enc_pkg::cNB-1:0]    seen = '0;
  int                              err_cnt = 0;
  int                              frame_cnt = 0;
  int                              release_cnt = 0;
  logic                            released = 1'b0;
  ldpc_enc_pkg::col_t              held_addr;

  assign errors = err_cnt;
  assign frames = frame_cnt;

  function automatic ldpc_enc_pkg::zdat_t rotate_left(ldpc_enc_pkg::zdat_t w, int n);
    return ldpc_enc_pkg::zdat_t'((w << n) | (w >> (cW - n)));
  endfunction

  //------------------------------------------------------------------------
  // reference encoder, one output word
  //------------------------------------------------------------------------
  function automatic ldpc_enc_pkg::zdat_t expected_word(
    logic [ldpc_enc_pkg::cKB*cW-1:0] words, int addr);
    ldpc_enc_pkg::zdat_t     acc [ldpc_enc_pkg::cMB];
    ldpc_enc_pkg::zdat_t     par;
    ldpc_enc_pkg::hs_entry_t e;
    if (addr < ldpc_enc_pkg::cKB) begin
      return words[addr*cW +: cW];
    end
    for (int r = 0; r < ldpc_enc_pkg::cMB; r++) begin
      acc[r] = '0;
    end
    for (int i = 0; i < ldpc_enc_pkg::cHS_NUM; i++) begin
      e = ldpc_enc_pkg::cHS_TABLE[i];
      acc[e.row] = acc[e.row] ^ rotate_left(words[int'(e.col)*cW +: cW], int'(e.shift));
    end
    // dual diagonal chain up to this row
    par = '0;
    for (int r = 0; r <= addr - ldpc_enc_pkg::cKB; r++) begin
      par = par ^ acc[r];
    end
    return par;
  endfunction

  task automatic close_frame();
    logic [ldpc_enc_pkg::cKB*cW-1:0] words;
    if (release_cnt != 1) begin
      $display("input buffer released %0d times in frame %0d", release_cnt, frame_cnt);
      err_cnt++;
    end
    if (exp_q.size() == 0) begin
      $display("output frame finished at %0t with no input frame loaded", $time);
      err_cnt++;
    end
    else begin
      words = exp_q.pop_front();
      for (int a = 0; a < ldpc_enc_pkg::cNB; a++) begin
        if (!seen[a]) begin
          $display("frame %0d address %0d never written", frame_cnt, a);
          err_cnt++;
        end
        else if (got[a] !== expected_word(words, a)) begin
          $display("Mismatch at %0t: frame %0d address %0d got %02h expected %02h",
                   $time, frame_cnt, a, got[a], expected_word(words, a));
          err_cnt++;
        end
      end
    end
    frame_cnt++;
    seen        = '0;
    release_cnt = 0;
    released    = 1'b0;
  endtask

  //------------------------------------------------------------------------
  // monitor, sampled on the rising edge
  //------------------------------------------------------------------------
  always @(posedge iclk) begin
    if (ireset) begin
      if (wr_en || wr_full || rd_release) begin
        $display("engine output active during reset at %0t", $time);
        err_cnt++;
      end
    end
    else begin
      if (load) begin
        exp_q.push_back(load_words);
      end
      if (wr_en) begin
        if (!wbuf_empty) begin
          $display("write at %0t while the output buffer is not empty", $time);
          err_cnt++;
        end
        if (seen[wr_addr]) begin
          $display("address %0d written twice at %0t", wr_addr, $time);
          err_cnt++;
        end
        else begin
          seen[wr_addr] = 1'b1;
          got[wr_addr]  = wr_dat;
        end
      end
      // read address frozen once the buffer is released
      if (released && (rd_addr !== held_addr)) begin
        $display("input buffer read after release at %0t", $time);
        err_cnt++;
      end
      if (rd_release) begin
        release_cnt++;
        released  = 1'b1;
        held_addr = rd_addr;
      end
      if (wr_full) begin
        close_frame();
      end
    end
  end

endmodule

// ==== dv/ldpc_enc_tb.sv ====
//--------------------------------------------------------------------------
// QC LDPC encoder testbench
// random frames through buffer models around the engine, checker attached
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module ldpc_enc_tb;

  localparam int          cFRAMES       = 40;
  localparam int          cCLK_PERIOD   = 4;
  localparam int          cFRAME_CYCLES = 200;
  localparam logic [31:0] cSEED         = 32'd81076;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] cLFSR_TAPS    = 32'h80200003;

  logic                 iclk;
  logic                 ireset;
  logic                 irbuf_full;
  ldpc_enc_pkg::zdat_t  irdat;
  ldpc_enc_pkg::col_t   oraddr;
  logic                 orempty;
  logic                 iwbuf_empty;
  logic                 owrite;
  ldpc_enc_pkg::col_t   owaddr;
  ldpc_enc_pkg::zdat_t  owdat;
  logic                 owfull;
  // input buffer contents and read pipe
  ldpc_enc_pkg::zdat_t  in_mem [ldpc_enc_pkg::cKB];
  ldpc_enc_pkg::zdat_t  rd_q0;
  ldpc_enc_pkg::zdat_t  rd_q1;
  // frame handed to the checker
  logic                 load;
  logic [ldpc_enc_pkg::cKB*ldpc_enc_pkg::cZ-1:0] load_words;
  int                   err_cnt;
  int                   frame_cnt;
  logic [31:0]          lfsr = cSEED;

  // galois form, shift right, taps on the lsb out
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ cLFSR_TAPS) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  ldpc_enc_engine u_ldpc_enc_engine (
    .iclk        ( iclk        ),
    .ireset      ( ireset      ),
    .irbuf_full  ( irbuf_full  ),
    .irdat       ( irdat       ),
    .oraddr      ( oraddr      ),
    .orempty     ( orempty     ),
    .iwbuf_empty ( iwbuf_empty ),
    .owrite      ( owrite      ),
    .owaddr      ( owaddr      ),
    .owdat       ( owdat       ),
    .owfull      ( owfull      )
  );

  ldpc_enc_checker u_checker (
    .iclk       ( iclk        ),
    .ireset     ( ireset      ),
    .rd_addr    ( oraddr      ),
    .rd_release ( orempty     ),
    .wbuf_empty ( iwbuf_empty ),
    .wr_en      ( owrite      ),
    .wr_addr    ( owaddr      ),
    .wr_dat     ( owdat       ),
    .wr_full    ( owfull      ),
    .load       ( load        ),
    .load_words ( load_words  ),
    .errors     ( err_cnt     ),
    .frames     ( frame_cnt   )
  );

  //------------------------------------------------------------------------
  // clock and reset
  //------------------------------------------------------------------------
  initial begin
    iclk = 1'b0;
    forever #(cCLK_PERIOD / 2) iclk = ~iclk;
  end

  initial begin
    ireset      = 1'b1;
    irbuf_full  = 1'b0;
    irdat       = '0;
    iwbuf_empty = 1'b1;
    load        = 1'b0;
    load_words  = '0;
    rd_q0       = '0;
    rd_q1       = '0;
    for (int w = 0; w < ldpc_enc_pkg::cKB; w++) begin
      in_mem[w[1:0]] = '0;
    end
    repeat (2) @(negedge iclk);
    ireset <= 1'b0;
  end

  //------------------------------------------------------------------------
  // input buffer model
  //------------------------------------------------------------------------
  // read data latched at address time, 2 cycles to irdat
  always @(negedge iclk) begin
    rd_q0 <= $isunknown(oraddr) ? '0 : in_mem[oraddr[1:0]];
    rd_q1 <= rd_q0;
    irdat <= rd_q1;
  end

  initial begin : input_buffer
    logic [31:0] bits;
    logic [ldpc_enc_pkg::cKB*ldpc_enc_pkg::cZ-1:0] words;
    wait (ireset == 1'b0);
    for (int f = 0; f < cFRAMES; f++) begin
      // at least one cycle past the release
      @(negedge iclk);
      take_bits(3, bits);
      repeat (bits) @(negedge iclk);
      for (int w = 0; w < ldpc_enc_pkg::cKB; w++) begin
        take_bits(ldpc_enc_pkg::cZ, bits);
        in_mem[w[1:0]] <= bits[ldpc_enc_pkg::cZ-1:0];
        words[w*ldpc_enc_pkg::cZ +: ldpc_enc_pkg::cZ] = bits[ldpc_enc_pkg::cZ-1:0];
      end
      load_words <= words;
      load       <= 1'b1;
      irbuf_full <= 1'b1;
      @(negedge iclk);
      load <= 1'b0;
      // hold until the engine frees the buffer
      while (!orempty) @(negedge iclk);
      irbuf_full <= 1'b0;
    end
  end

  //------------------------------------------------------------------------
  // output buffer model, drains after each owfull
  //------------------------------------------------------------------------
  initial begin : output_buffer
    logic [31:0] bits;
    wait (ireset == 1'b0);
    forever begin
      @(negedge iclk);
      while (!owfull) @(negedge iclk);
      iwbuf_empty <= 1'b0;
      take_bits(3, bits);
      repeat (bits + 1) @(negedge iclk);
      iwbuf_empty <= 1'b1;
    end
  end

  //------------------------------------------------------------------------
  // end of run
  //------------------------------------------------------------------------
  initial begin : run_control
    wait (ireset == 1'b0);
    wait (frame_cnt == cFRAMES);
    repeat (10) @(negedge iclk);
    $display("frames %0d of %0d, errors %0d", frame_cnt, cFRAMES, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end
    else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // limit sized for the worst case frame with buffer delays
  initial begin : watchdog
    #(cFRAMES * cFRAME_CYCLES * cCLK_PERIOD);
    $display("timeout at %0t, frames %0d of %0d, errors %0d",
             $time, frame_cnt, cFRAMES, err_cnt);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== vlog.f ====
hdl/ldpc_enc_pkg.sv
hdl/ldpc_enc_entry_if.sv
hdl/ldpc_enc_hs_table.sv
hdl/ldpc_enc_ctrl.sv
hdl/ldpc_enc_rotator.sv
hdl/ldpc_enc_pacc.sv
hdl/ldpc_enc_out_mux.sv
hdl/ldpc_enc_engine.sv
dv/ldpc_enc_checker.sv
dv/ldpc_enc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the LDPC encoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module ldpc_enc_tb

out=$(./obj_dir/Vldpc_enc_tb)
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
